// ==== Bender.yml ====
package:
  name: driver_memory

sources:
  - files:
      - logic/mem_map_pkg.sv
      - logic/payload_pkg.sv
      - logic/segment_ram.sv
      - logic/controller_regs.sv
      - logic/memory_map.sv
      - logic/modulation_player.sv
      - logic/driver_memory_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_driver_memory.sv

// ==== flist.f ====
+incdir+include
logic/mem_map_pkg.sv
logic/payload_pkg.sv
logic/segment_ram.sv
logic/controller_regs.sv
logic/memory_map.sv
logic/modulation_player.sv
logic/driver_memory_top.sv
testbench/tb_driver_memory.sv

// ==== logic/controller_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module controller_regs
  import mem_map_pkg::*;
  import payload_pkg::*;
#(
  parameter int num_segment = 2,
  parameter int stm_addr_width = 10,
  localparam int seg_width = (num_segment > 1) ? $clog2(num_segment) : 1,
  localparam int page_width = stm_addr_width - 8
) (
  input wire logic bus_clk,
  input wire logic rst,

  // Host side
  input wire logic host_en,
  input wire logic host_we,
  input wire logic [7:0] host_addr,
  input wire host_word_t host_din,
  output host_word_t host_dout,

  // Controller side
  input wire logic ctl_we,
  input wire logic [7:0] ctl_addr,
  input wire host_word_t ctl_din,
  output host_word_t ctl_dout,

  // Routing for host writes into the other memories
  output logic [seg_width-1:0] mod_wr_segment,
  output logic [seg_width-1:0] stm_wr_segment,
  output logic [page_width-1:0] stm_wr_page
);

  host_word_t ram [256];

  logic host_wr;
  logic [2:0] wr_hist;
  logic snoop_load;

  assign host_wr = host_en & host_we;

  // Two writers on one array and collisions are left to the caller
  always_ff @(posedge bus_clk) begin
    if (host_wr) begin
      ram[host_addr] <= host_din;
    end
    if (ctl_we) begin
      ram[ctl_addr] <= ctl_din;
    end
    ctl_dout <= ram[ctl_addr];
  end

  // Host read data holds until the next host read
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      host_dout <= '0;
    end else if (host_en && !host_we) begin
      host_dout <= ram[host_addr];
    end
  end

  // Strobe was low, then high for two cycles, and is still high.
  // The host has held the word long enough for it to be stable.
  assign snoop_load = (wr_hist == 3'b011) & host_wr;

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_hist <= '0;
      mod_wr_segment <= '0;
      stm_wr_segment <= '0;
      stm_wr_page <= '0;
    end else begin
      wr_hist <= {wr_hist[1:0], host_wr};
      if (snoop_load) begin
        case (host_addr)
          addr_mod_wr_segment: mod_wr_segment <= host_din[seg_width-1:0];
          addr_stm_wr_segment: stm_wr_segment <= host_din[seg_width-1:0];
          addr_stm_wr_page:    stm_wr_page <= host_din[page_width-1:0];
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/driver_memory_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module driver_memory_top
  import mem_map_pkg::*;
  import payload_pkg::*;
#(
  parameter int num_segment = 2,
  parameter int mod_addr_width = 10,
  parameter int stm_addr_width = 10,
  localparam int seg_width = (num_segment > 1) ? $clog2(num_segment) : 1
) (
  input wire logic bus_clk,
  input wire logic rst,

  // Host bus
  input wire bank_select_t bank_select,
  input wire logic en,
  input wire logic we,
  input wire logic [host_addr_width-1:0] addr,
  input wire host_word_t data_in,
  output host_word_t data_out,

  // Controller port
  input wire logic ctl_we,
  input wire logic [7:0] ctl_addr,
  input wire host_word_t ctl_din,
  output host_word_t ctl_dout,

  // STM read port
  input wire logic [stm_addr_width-1:0] stm_addr,
  input wire logic [seg_width-1:0] stm_segment,
  output stm_point_t stm_value,

  // Modulation player control and output
  input wire logic run,
  input wire logic [seg_width-1:0] mod_segment_sel,
  input wire logic [mod_addr_width:0] mod_cycle,
  output pwe_value_t pulse_width,
  output logic pulse_valid
);

  logic [mod_addr_width-1:0] mod_idx;
  logic [seg_width-1:0] mod_segment;
  mod_value_t mod_value;
  logic [7:0] pwe_idx;
  pwe_value_t pwe_value;

  memory_map #(
    .num_segment(num_segment),
    .mod_addr_width(mod_addr_width),
    .stm_addr_width(stm_addr_width)
  ) u_memory_map (
    .bus_clk(bus_clk),
    .rst(rst),
    .bank_select(bank_select),
    .en(en),
    .we(we),
    .addr(addr),
    .data_in(data_in),
    .data_out(data_out),
    .ctl_we(ctl_we),
    .ctl_addr(ctl_addr),
    .ctl_din(ctl_din),
    .ctl_dout(ctl_dout),
    .mod_idx(mod_idx),
    .mod_segment(mod_segment),
    .mod_value(mod_value),
    .pwe_idx(pwe_idx),
    .pwe_value(pwe_value),
    .stm_addr(stm_addr),
    .stm_segment(stm_segment),
    .stm_value(stm_value)
  );

  modulation_player #(
    .num_segment(num_segment),
    .mod_addr_width(mod_addr_width)
  ) u_modulation_player (
    .bus_clk(bus_clk),
    .rst(rst),
    .run(run),
    .mod_segment_sel(mod_segment_sel),
    .mod_cycle(mod_cycle),
    .mod_idx(mod_idx),
    .mod_segment(mod_segment),
    .mod_value(mod_value),
    .pwe_idx(pwe_idx),
    .pwe_value(pwe_value),
    .pulse_width(pulse_width),
    .pulse_valid(pulse_valid)
  );

endmodule

`default_nettype wire

// ==== logic/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

  // Host bus width in address bits
  localparam int host_addr_width = 14;

  // Which memory a host access goes to
  typedef enum logic [1:0] {
    bank_controller = 2'd0,
    bank_mod        = 2'd1,
    bank_pwe        = 2'd2,
    bank_stm        = 2'd3
  } bank_select_t;

  // Value of host address bits 13..8 that picks the controller RAM.
  // Other values in the controller bank are reserved and ignored.
  localparam logic [5:0] cnt_select_main = 6'd0;

  // Controller word addresses that are also snooped into
  // the write routing registers
  localparam logic [7:0] addr_mod_wr_segment = 8'h06;
  localparam logic [7:0] addr_stm_wr_segment = 8'h07;
  localparam logic [7:0] addr_stm_wr_page    = 8'h08;

endpackage

`default_nettype wire

// ==== logic/memory_map.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_map
  import mem_map_pkg::*;
  import payload_pkg::*;
#(
  parameter int num_segment = 2,
  parameter int mod_addr_width = 10,
  parameter int stm_addr_width = 10,
  localparam int seg_width = (num_segment > 1) ? $clog2(num_segment) : 1,
  localparam int page_width = stm_addr_width - 8
) (
  input wire logic bus_clk,
  input wire logic rst,

  // Host bus
  input wire bank_select_t bank_select,
  input wire logic en,
  input wire logic we,
  input wire logic [host_addr_width-1:0] addr,
  input wire host_word_t data_in,
  output host_word_t data_out,

  // Controller port
  input wire logic ctl_we,
  input wire logic [7:0] ctl_addr,
  input wire host_word_t ctl_din,
  output host_word_t ctl_dout,

  // Modulation read port
  input wire logic [mod_addr_width-1:0] mod_idx,
  input wire logic [seg_width-1:0] mod_segment,
  output mod_value_t mod_value,

  // Pulse-width table read port
  input wire logic [7:0] pwe_idx,
  output pwe_value_t pwe_value,

  // STM read port
  input wire logic [stm_addr_width-1:0] stm_addr,
  input wire logic [seg_width-1:0] stm_segment,
  output stm_point_t stm_value
);

  logic ctl_host_en;
  logic mod_wr_en;
  logic pwe_wr_en;
  logic stm_wr_en;

  logic [seg_width-1:0] mod_wr_segment;
  logic [seg_width-1:0] stm_wr_segment;
  logic [page_width-1:0] stm_wr_page;

  // Bank decode
  // The controller RAM only answers on its own sub-select
  assign ctl_host_en = en && (bank_select == bank_controller) &&
                       (addr[13:8] == cnt_select_main);
  assign mod_wr_en = en && we && (bank_select == bank_mod);
  assign pwe_wr_en = en && we && (bank_select == bank_pwe);
  assign stm_wr_en = en && we && (bank_select == bank_stm);

  controller_regs #(
    .num_segment(num_segment),
    .stm_addr_width(stm_addr_width)
  ) u_controller_regs (
    .bus_clk(bus_clk),
    .rst(rst),
    .host_en(ctl_host_en),
    .host_we(we),
    .host_addr(addr[7:0]),
    .host_din(data_in),
    .host_dout(data_out),
    .ctl_we(ctl_we),
    .ctl_addr(ctl_addr),
    .ctl_din(ctl_din),
    .ctl_dout(ctl_dout),
    .mod_wr_segment(mod_wr_segment),
    .stm_wr_segment(stm_wr_segment),
    .stm_wr_page(stm_wr_page)
  );

  segment_ram #(
    .num_segment(num_segment),
    .addr_width(mod_addr_width),
    .payload_t(mod_value_t)
  ) u_mod_ram (
    .bus_clk(bus_clk),
    .wr_en(mod_wr_en),
    .wr_segment(mod_wr_segment),
    .wr_addr(addr[mod_addr_width-1:0]),
    .wr_data(data_in[7:0]),
    .rd_addr(mod_idx),
    .rd_segment(mod_segment),
    .rd_data(mod_value)
  );

  // Single table with the segment tied off
  segment_ram #(
    .num_segment(1),
    .addr_width(8),
    .payload_t(pwe_value_t)
  ) u_pwe_ram (
    .bus_clk(bus_clk),
    .wr_en(pwe_wr_en),
    .wr_segment(1'b0),
    .wr_addr(addr[7:0]),
    .wr_data(data_in[7:0]),
    .rd_addr(pwe_idx),
    .rd_segment(1'b0),
    .rd_data(pwe_value)
  );

  // Host sees 256 points at a time and the page register supplies the rest
  segment_ram #(
    .num_segment(num_segment),
    .addr_width(stm_addr_width),
    .payload_t(stm_point_t)
  ) u_stm_ram (
    .bus_clk(bus_clk),
    .wr_en(stm_wr_en),
    .wr_segment(stm_wr_segment),
    .wr_addr({stm_wr_page, addr[7:0]}),
    .wr_data(stm_point_t'(data_in)),
    .rd_addr(stm_addr),
    .rd_segment(stm_segment),
    .rd_data(stm_value)
  );

endmodule

`default_nettype wire

// ==== logic/modulation_player.sv ====
`timescale 1ns/1ns
`default_nettype none

module modulation_player
  import payload_pkg::*;
#(
  parameter int num_segment = 2,
  parameter int mod_addr_width = 10,
  localparam int seg_width = (num_segment > 1) ? $clog2(num_segment) : 1
) (
  input wire logic bus_clk,
  input wire logic rst,

  input wire logic run,
  input wire logic [seg_width-1:0] mod_segment_sel,
  // One bit wider than the index so a full-depth loop fits
  input wire logic [mod_addr_width:0] mod_cycle,

  output logic [mod_addr_width-1:0] mod_idx,
  output logic [seg_width-1:0] mod_segment,
  input wire mod_value_t mod_value,

  output logic [7:0] pwe_idx,
  input wire pwe_value_t pwe_value,

  output pwe_value_t pulse_width,
  output logic pulse_valid
);

  logic [mod_addr_width:0] last_idx;
  logic idx_wrap;
  logic mod_valid;

  assign last_idx = mod_cycle - 1'b1;
  assign idx_wrap = ({1'b0, mod_idx} == last_idx);

  // Index is issued in every cycle that run is high
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      mod_idx <= '0;
      mod_segment <= '0;
    end else begin
      mod_segment <= mod_segment_sel;
      if (!run || idx_wrap) begin
        mod_idx <= '0;
      end else begin
        mod_idx <= mod_idx + 1'b1;
      end
    end
  end

  // Valid follows the two memory reads
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      mod_valid <= 1'b0;
      pulse_valid <= 1'b0;
    end else begin
      mod_valid <= run;
      pulse_valid <= mod_valid;
    end
  end

  // Modulation byte indexes the pulse-width table directly
  assign pwe_idx = mod_value;
  assign pulse_width = pwe_value;

endmodule

`default_nettype wire

// ==== logic/payload_pkg.sv ====
`default_nettype none

package payload_pkg;

  // Word carried on the host bus and stored in the controller RAM
  typedef logic [15:0] host_word_t;

  // Modulation entry
  typedef logic [7:0] mod_value_t;

  // Pulse width produced by the lookup table
  typedef logic [7:0] pwe_value_t;

  // One STM point with intensity in the upper byte
  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
  } stm_point_t;

endpackage

`default_nettype wire

// ==== logic/segment_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module segment_ram #(
  parameter int num_segment = 2,
  parameter int addr_width = 10,
  parameter type payload_t = logic [7:0],
  localparam int seg_width = (num_segment > 1) ? $clog2(num_segment) : 1
) (
  input wire logic bus_clk,
  input wire logic wr_en,
  input wire logic [seg_width-1:0] wr_segment,
  input wire logic [addr_width-1:0] wr_addr,
  input wire payload_t wr_data,
  input wire logic [addr_width-1:0] rd_addr,
  input wire logic [seg_width-1:0] rd_segment,
  output payload_t rd_data
);

  localparam int depth = 2 ** addr_width;

  // Every bank reads each cycle and the segment is picked afterwards
  payload_t bank_q [num_segment];
  logic [seg_width-1:0] rd_segment_q;

  for (genvar s = 0; s < num_segment; s++) begin : gen_bank
    payload_t mem [depth];

    always_ff @(posedge bus_clk) begin
      if (wr_en && (wr_segment == seg_width'(s))) begin
        mem[wr_addr] <= wr_data;
      end
      // Read before write on a same-address hit
      bank_q[s] <= mem[rd_addr];
    end
  end

  // Segment travels with the address so the mux lines up with the data
  always_ff @(posedge bus_clk) begin
    rd_segment_q <= rd_segment;
  end

  assign rd_data = bank_q[rd_segment_q];

endmodule

`default_nettype wire

// ==== include/tb_host_tasks.svh ====
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// Included inside the testbench module after its host bus signals and
// its num_segment, mod_addr_width and stm_addr_width localparams

// Reference models
host_word_t ref_ctl [256];
mod_value_t ref_mod [num_segment][2 ** mod_addr_width];
pwe_value_t ref_pwe [256];
stm_point_t ref_stm [num_segment][2 ** stm_addr_width];
logic [15:0] ref_mod_wr_segment;
logic [15:0] ref_stm_wr_segment;
logic [15:0] ref_stm_wr_page;

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// Held for three cycles so the snoop logic sees every controller write
task automatic host_write(input bank_select_t bank, input logic [13:0] a,
                          input host_word_t d);
  @(posedge bus_clk);
  #1;
  bank_select = bank;
  en = 1'b1;
  we = 1'b1;
  addr = a;
  data_in = d;
  repeat (3) @(posedge bus_clk);
  #1;
  en = 1'b0;
  we = 1'b0;
endtask

// Data is taken one cycle after the read cycle
task automatic host_read(input logic [13:0] a, output host_word_t d);
  @(posedge bus_clk);
  #1;
  bank_select = bank_controller;
  en = 1'b1;
  we = 1'b0;
  addr = a;
  @(posedge bus_clk);
  #1;
  en = 1'b0;
  d = data_out;
endtask

`endif

// ==== testbench/tb_driver_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_driver_memory
  import mem_map_pkg::*;
  import payload_pkg::*;
();

  localparam int num_segment = 2;
  localparam int mod_addr_width = 10;
  localparam int stm_addr_width = 10;
  localparam int seg_width = (num_segment > 1) ? $clog2(num_segment) : 1;
  localparam int page_width = stm_addr_width - 8;
  // About 350 held writes at 4 cycles each, plus reads and three player runs
  localparam int max_cycles = 20000;

  logic bus_clk;
  logic rst;
  bank_select_t bank_select;
  logic en;
  logic we;
  logic [host_addr_width-1:0] addr;
  host_word_t data_in;
  host_word_t data_out;
  logic ctl_we;
  logic [7:0] ctl_addr;
  host_word_t ctl_din;
  host_word_t ctl_dout;
  logic [stm_addr_width-1:0] stm_addr;
  logic [seg_width-1:0] stm_segment;
  stm_point_t stm_value;
  logic run;
  logic [seg_width-1:0] mod_segment_sel;
  logic [mod_addr_width:0] mod_cycle;
  pwe_value_t pulse_width;
  logic pulse_valid;

  int checks;
  int errors;
  int pulse_count;
  int cycle_count;
  logic [31:0] rng;

  // Expected player pipeline
  int model_idx;
  logic [1:0] exp_vld_q;
  pwe_value_t exp_pw_q [2];

  `include "tb_host_tasks.svh"

  always #5 bus_clk = ~bus_clk;

  driver_memory_top #(
    .num_segment(num_segment),
    .mod_addr_width(mod_addr_width),
    .stm_addr_width(stm_addr_width)
  ) u_driver_memory_top (
    .bus_clk(bus_clk),
    .rst(rst),
    .bank_select(bank_select),
    .en(en),
    .we(we),
    .addr(addr),
    .data_in(data_in),
    .data_out(data_out),
    .ctl_we(ctl_we),
    .ctl_addr(ctl_addr),
    .ctl_din(ctl_din),
    .ctl_dout(ctl_dout),
    .stm_addr(stm_addr),
    .stm_segment(stm_segment),
    .stm_value(stm_value),
    .run(run),
    .mod_segment_sel(mod_segment_sel),
    .mod_cycle(mod_cycle),
    .pulse_width(pulse_width),
    .pulse_valid(pulse_valid)
  );

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("error %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // Controller word through the host with the snooped registers tracked
  task automatic store_ctl_word(input logic [7:0] a, input host_word_t d);
    host_write(bank_controller, {cnt_select_main, a}, d);
    ref_ctl[a] = d;
    case (a)
      addr_mod_wr_segment: ref_mod_wr_segment = d;
      addr_stm_wr_segment: ref_stm_wr_segment = d;
      addr_stm_wr_page: ref_stm_wr_page = d;
      default: begin
      end
    endcase
  endtask

  task automatic load_mod_byte(input logic [mod_addr_width-1:0] idx, input mod_value_t b);
    host_write(bank_mod, host_addr_width'(idx), {8'h00, b});
    ref_mod[ref_mod_wr_segment[seg_width-1:0]][idx] = b;
  endtask

  task automatic load_pwe_entry(input logic [7:0] idx, input pwe_value_t w);
    host_write(bank_pwe, {6'd0, idx}, {8'h00, w});
    ref_pwe[idx] = w;
  endtask

  task automatic load_stm_point(input logic [7:0] a, input stm_point_t p);
    host_write(bank_stm, {6'd0, a}, p);
    ref_stm[ref_stm_wr_segment[seg_width-1:0]][{ref_stm_wr_page[page_width-1:0], a}] = p;
  endtask

  task automatic port_write(input logic [7:0] a, input host_word_t d);
    @(posedge bus_clk);
    #1;
    ctl_we = 1'b1;
    ctl_addr = a;
    ctl_din = d;
    @(posedge bus_clk);
    #1;
    ctl_we = 1'b0;
    ref_ctl[a] = d;
  endtask

  task automatic port_read(input logic [7:0] a, output host_word_t d);
    @(posedge bus_clk);
    #1;
    ctl_addr = a;
    @(posedge bus_clk);
    #1;
    d = ctl_dout;
  endtask

  task automatic read_stm_point(input logic [seg_width-1:0] s,
                                input logic [stm_addr_width-1:0] a, output stm_point_t p);
    @(posedge bus_clk);
    #1;
    stm_addr = a;
    stm_segment = s;
    @(posedge bus_clk);
    #1;
    p = stm_value;
  endtask

  // Index, lookup and valid as the player should produce them
  always @(posedge bus_clk) begin
    if (rst) begin
      model_idx <= 0;
      exp_vld_q <= '0;
    end else begin
      exp_vld_q <= {exp_vld_q[0], run};
      exp_pw_q[1] <= exp_pw_q[0];
      exp_pw_q[0] <= ref_pwe[ref_mod[mod_segment_sel][model_idx]];
      if (!run || model_idx == int'(mod_cycle) - 1) begin
        model_idx <= 0;
      end else begin
        model_idx <= model_idx + 1;
      end
    end
  end

  always @(negedge bus_clk) begin
    if (!rst) begin
      if (pulse_valid) begin
        pulse_count++;
      end
      if (exp_vld_q[1]) begin
        check_value("pulse_width", exp_pw_q[1], pulse_width);
      end
    end
  end

  pulse_valid_tracks_run: assert property (
    @(posedge bus_clk) disable iff (rst) pulse_valid == $past(run, 2)
  ) else begin
    errors++;
    $display("error pulse_valid expected %0b actual %0b",
             !$sampled(pulse_valid), $sampled(pulse_valid));
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge bus_clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", max_cycles);
    $display("Regression failed");
    $finish;
  end

  initial begin : main_sequence
    host_word_t rd;
    host_word_t held;
    stm_point_t p;
    logic [7:0] a;
    logic [7:0] ctl_addr_q [$];
    logic [seg_width-1:0] stm_seg_q [$];
    logic [stm_addr_width-1:0] stm_addr_q [$];

    bus_clk = 1'b0;
    rst = 1'b1;
    bank_select = bank_controller;
    en = 1'b0;
    we = 1'b0;
    addr = '0;
    data_in = '0;
    ctl_we = 1'b0;
    ctl_addr = '0;
    ctl_din = '0;
    stm_addr = '0;
    stm_segment = '0;
    run = 1'b0;
    mod_segment_sel = '0;
    mod_cycle = '0;
    checks = 0;
    errors = 0;
    pulse_count = 0;
    rng = 32'd49929;
    ref_mod_wr_segment = '0;
    ref_stm_wr_segment = '0;
    ref_stm_wr_page = '0;
    repeat (5) @(posedge bus_clk);
    #1;
    rst = 1'b0;
    check_value("reset_data_out", 16'h0000, data_out);
    check_value("reset_pulse_valid", 1'b0, pulse_valid);

    // Controller round trip through the host side and then the controller side
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      a = 8'h20 + 8'(rng[7:0] % 224);
      store_ctl_word(a, rng[31:16]);
      ctl_addr_q.push_back(a);
    end
    foreach (ctl_addr_q[i]) begin
      host_read({cnt_select_main, ctl_addr_q[i]}, rd);
      check_value("ctl_host_read", ref_ctl[ctl_addr_q[i]], rd);
      port_read(ctl_addr_q[i], rd);
      check_value("ctl_port_read", ref_ctl[ctl_addr_q[i]], rd);
    end
    for (int i = 0; i < 4; i++) begin
      rng = xorshift(rng);
      port_write(8'h10 + 8'(i), rng[15:0]);
      host_read({cnt_select_main, 8'h10 + 8'(i)}, rd);
      check_value("ctl_port_to_host", ref_ctl[8'h10 + 8'(i)], rd);
    end
    held = ref_ctl[8'h13];

    // Routing registers start at segment 0, page 0
    rng = xorshift(rng);
    load_stm_point(8'h05, rng[15:0]);
    read_stm_point('0, stm_addr_width'(8'h05), p);
    check_value("stm_reset_route", ref_stm[0][8'h05], p);
    check_value("data_out_hold", held, data_out);

    // Modulation bytes go to segment 0 and are then rerouted to segment 1
    for (int i = 0; i < 16; i++) begin
      rng = xorshift(rng);
      load_mod_byte(mod_addr_width'(i), rng[7:0]);
    end
    store_ctl_word(addr_mod_wr_segment, 16'h0001);
    host_read({cnt_select_main, addr_mod_wr_segment}, rd);
    check_value("mod_segment_word", 16'h0001, rd);
    for (int i = 0; i < 16; i++) begin
      rng = xorshift(rng);
      load_mod_byte(mod_addr_width'(i), rng[7:0]);
    end

    // STM points over both segments and every page
    for (int s = 0; s < num_segment; s++) begin
      for (int pg = 0; pg < 4; pg++) begin
        store_ctl_word(addr_stm_wr_segment, host_word_t'(s));
        store_ctl_word(addr_stm_wr_page, host_word_t'(pg));
        for (int k = 0; k < 4; k++) begin
          rng = xorshift(rng);
          a = rng[7:0];
          load_stm_point(a, rng[23:8]);
          stm_seg_q.push_back(seg_width'(s));
          stm_addr_q.push_back({page_width'(pg), a});
        end
      end
    end
    foreach (stm_addr_q[i]) begin
      read_stm_point(stm_seg_q[i], stm_addr_q[i], p);
      check_value("stm_read", ref_stm[stm_seg_q[i]][stm_addr_q[i]], p);
    end

    for (int i = 0; i < 256; i++) begin
      rng = xorshift(rng);
      load_pwe_entry(8'(i), rng[7:0]);
    end

    // Player runs on segment 0 and then on segment 1 with a shorter loop and a quick restart
    mod_cycle = 11'd12;
    mod_segment_sel = 1'b0;
    @(posedge bus_clk);
    #1;
    run = 1'b1;
    repeat (40) @(posedge bus_clk);
    #1;
    run = 1'b0;
    repeat (4) @(posedge bus_clk);
    #1;
    mod_segment_sel = 1'b1;
    mod_cycle = 11'd7;
    @(posedge bus_clk);
    #1;
    run = 1'b1;
    repeat (30) @(posedge bus_clk);
    #1;
    run = 1'b0;
    repeat (2) @(posedge bus_clk);
    #1;
    run = 1'b1;
    repeat (10) @(posedge bus_clk);
    #1;
    run = 1'b0;
    repeat (5) @(posedge bus_clk);
    #1;
    check_value("pulse_count", 80, pulse_count);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
